// ==== common/ecc_mem_defines.svh ====
`ifndef ECC_MEM_DEFINES_SVH
`define ECC_MEM_DEFINES_SVH

// Data word width in bits.
`define ECC_DATA_W 32

// Hamming SEC codeword width, 32 data plus 6 parity.
`define ECC_CODE_W 38

// Syndrome width, enough to name positions 1 to 63.
`define ECC_SYN_W 6

// Address width, gives a depth of 256 words.
`define MEM_ADDR_W 8

// Width of the saturating corrected-read counter.
`define ECC_CNT_W 16

`endif

// ==== common/ecc_pkg.sv ====
`include "ecc_mem_defines.svh"

package ecc_pkg;

    // Stored codeword, bit i holds Hamming position i+1.
    typedef logic [`ECC_CODE_W-1:0] code_word_t;

    // Error position reported by the decoder, 0 means no error.
    typedef logic [`ECC_SYN_W-1:0] syndrome_t;

    // Read status.
    typedef enum logic [1:0] {
        ECC_CLEAN        = 2'd0, // Syndrome zero.
        ECC_CORRECTED    = 2'd1, // Syndrome inside the codeword, one bit flipped back.
        ECC_BAD_SYNDROME = 2'd2  // Syndrome past the last position, data passed raw.
    } ecc_status_e;

    // Positions 1, 2, 4, 8, 16, 32 carry parity; all others carry data.
    function automatic logic is_parity_pos(input int unsigned pos);
        return ((pos & (pos - 1)) == 0); // Power of two test.
    endfunction

endpackage

// ==== common/mem_pkg.sv ====
`include "ecc_mem_defines.svh"

package mem_pkg;

    // Word address into the storage array.
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // User data word, before encoding and after decoding.
    typedef logic [`ECC_DATA_W-1:0] mem_data_t;

    // Operation of the current cycle, write wins over read.
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0, // Idle cycle.
        OP_WRITE = 2'd1, // Store an encoded word.
        OP_READ  = 2'd2  // Fetch a codeword for decoding.
    } mem_op_e;

endpackage

// ==== common/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if import ecc_pkg::*, mem_pkg::*; ();

    logic       we;    // Write wcode to addr at the clock edge.
    logic       re;    // Load rcode from addr at the clock edge.
    mem_addr_t  addr;  // Shared address for both directions.
    code_word_t wcode; // Encoded word with inject mask applied.
    code_word_t rcode; // Registered array output, held between reads.

    // Controller side.
    modport ctrl (
        output we,
        output re,
        output addr,
        output wcode,
        input  rcode
    );

    // Storage array side.
    modport ram (
        input  we,
        input  re,
        input  addr,
        input  wcode,
        output rcode
    );

endinterface

// ==== ecc/ecc_enc32.sv ====
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_enc32 import ecc_pkg::*, mem_pkg::*; (
    input  mem_data_t  data, // Raw data word.
    output code_word_t code  // Hamming SEC codeword.
);

    code_word_t placed; // Data bits spread over their positions, parity slots zero.

    // Data bit 0 lands at position 3, data bit 31 at position 38.
    always_comb begin
        int unsigned d_idx;
        d_idx  = 0;
        placed = '0;
        for (int unsigned pos = 1; pos <= `ECC_CODE_W; pos++) begin
            if (!is_parity_pos(pos)) begin
                placed[pos-1] = data[d_idx]; // Next data bit in order.
                d_idx         = d_idx + 1;
            end
        end
    end

    // Parity bit at position 2**p covers every position with bit p set.
    always_comb begin
        code = placed;
        for (int unsigned p = 0; p < `ECC_SYN_W; p++) begin
            for (int unsigned pos = 1; pos <= `ECC_CODE_W; pos++) begin
                if (((pos >> p) & 1) == 1 && !is_parity_pos(pos)) begin
                    code[(1 << p) - 1] = code[(1 << p) - 1] ^ placed[pos-1];
                end
            end
        end
    end

endmodule

// ==== ecc/ecc_dec32.sv ====
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_dec32 import ecc_pkg::*, mem_pkg::*; (
    input  code_word_t  code,     // Codeword as read from storage.
    output mem_data_t   data,     // Data after single-bit correction.
    output syndrome_t   syndrome, // Position of the suspected flipped bit.
    output ecc_status_e status    // Clean, corrected or bad syndrome.
);

    code_word_t fixed; // Codeword with the addressed bit flipped back.

    // A valid codeword XORs to zero over the positions of its set bits.
    // A single flip leaves exactly that position behind.
    always_comb begin
        syndrome = '0;
        for (int unsigned pos = 1; pos <= `ECC_CODE_W; pos++) begin
            if (code[pos-1]) begin
                syndrome = syndrome ^ syndrome_t'(pos); // Parity and data positions alike.
            end
        end
    end

    // Classify the syndrome.
    always_comb begin
        if (syndrome == '0) begin
            status = ECC_CLEAN;
        end else if (syndrome <= `ECC_CODE_W) begin
            status = ECC_CORRECTED; // Points inside the word.
        end else begin
            status = ECC_BAD_SYNDROME; // Points past position 38, leave bits alone.
        end
    end

    // Flip back the single addressed bit, if any.
    always_comb begin
        fixed = code;
        for (int unsigned pos = 1; pos <= `ECC_CODE_W; pos++) begin
            if (syndrome == syndrome_t'(pos)) begin
                fixed[pos-1] = ~code[pos-1]; // Only one position can match.
            end
        end
    end

    // Gather the data bits from the non-parity positions, lowest first.
    always_comb begin
        int unsigned d_idx;
        d_idx = 0;
        data  = '0;
        for (int unsigned pos = 1; pos <= `ECC_CODE_W; pos++) begin
            if (!is_parity_pos(pos)) begin
                data[d_idx] = fixed[pos-1];
                d_idx       = d_idx + 1;
            end
        end
    end

endmodule

// ==== logic/ecc_ram.sv ====
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_ram import ecc_pkg::*; #(
    parameter int ADDR_W = `MEM_ADDR_W // Depth is 2**ADDR_W words.
) (
    input logic       clk,
    mem_port_if.ram   mem
);

    code_word_t store [0:(1 << ADDR_W) - 1]; // Codeword array, maps onto block RAM.

    // Synchronous write.
    always_ff @(posedge clk) begin
        if (mem.we) begin
            store[mem.addr[ADDR_W-1:0]] <= mem.wcode;
        end
    end

    // Registered read, output holds until the next read.
    always_ff @(posedge clk) begin
        if (mem.re) begin
            mem.rcode <= store[mem.addr[ADDR_W-1:0]]; // Valid one cycle after re.
        end
    end

endmodule

// ==== logic/ecc_mem_ctrl.sv ====
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_mem_ctrl import ecc_pkg::*, mem_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,       // Write strobe, wins over rd_en.
    input  logic                  rd_en,       // Read strobe.
    input  mem_addr_t             addr,
    input  mem_data_t             wr_data,
    input  code_word_t            inject_mask, // Bits to flip in the stored codeword.
    mem_port_if.ctrl              mem,
    output logic                  rd_valid,    // One-cycle pulse, two edges after rd_en.
    output mem_data_t             rd_data,
    output ecc_status_e           rd_status,
    output logic [`ECC_CNT_W-1:0] corr_count   // Saturating count of corrected reads.
);

    mem_op_e     op;         // Operation of this cycle.
    code_word_t  enc_code;   // Encoder output before injection.
    logic [1:0]  rd_pipe;    // Read in flight, stage 0 at the array, stage 1 at the decoder.
    code_word_t  code_q;     // Codeword captured from the array output.
    mem_data_t   dec_data;   // Decoder data.
    ecc_status_e dec_status; // Decoder status.

    // Strobe decode.
    always_comb begin
        if (wr_en) begin
            op = OP_WRITE; // A read in the same cycle is dropped.
        end else if (rd_en) begin
            op = OP_READ;
        end else begin
            op = OP_NONE;
        end
    end

    ecc_enc32 u_enc (
        .data (wr_data),
        .code (enc_code)
    );

    // Array access happens in the issuing cycle.
    assign mem.we    = (op == OP_WRITE);
    assign mem.re    = (op == OP_READ);
    assign mem.addr  = addr;
    assign mem.wcode = enc_code ^ inject_mask; // Diagnostic corruption.

    ecc_dec32 u_dec (
        .code     (code_q),
        .data     (dec_data),
        .syndrome (),
        .status   (dec_status)
    );

    // Control state.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pipe    <= '0;
            rd_valid   <= 1'b0;
            rd_status  <= ECC_CLEAN;
            corr_count <= '0;
        end else begin
            rd_pipe  <= {rd_pipe[0], (op == OP_READ)}; // Shift the read marker.
            rd_valid <= rd_pipe[1];
            if (rd_pipe[1]) begin
                rd_status <= dec_status;
            end
            // Count corrected reads, stick at all ones.
            if (rd_pipe[1] && dec_status == ECC_CORRECTED && !(&corr_count)) begin
                corr_count <= corr_count + 1'b1;
            end
        end
    end

    // Payload registers, loaded only when their stage is live.
    always_ff @(posedge clk) begin
        if (rd_pipe[0]) begin
            code_q <= mem.rcode; // Array output is valid now.
        end
        if (rd_pipe[1]) begin
            rd_data <= dec_data; // Lands with rd_valid.
        end
    end

endmodule

// ==== logic/ecc_mem_top.sv ====
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_mem_top import ecc_pkg::*, mem_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,       // Synchronous, active high.
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  mem_addr_t             addr,
    input  mem_data_t             wr_data,
    input  code_word_t            inject_mask, // Sampled with wr_en only.
    output logic                  rd_valid,
    output mem_data_t             rd_data,
    output ecc_status_e           rd_status,
    output logic [`ECC_CNT_W-1:0] corr_count
);

    mem_port_if u_mem_if (); // Controller to array link.

    ecc_mem_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (addr),
        .wr_data     (wr_data),
        .inject_mask (inject_mask),
        .mem         (u_mem_if.ctrl),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_status   (rd_status),
        .corr_count  (corr_count)
    );

    ecc_ram #(
        .ADDR_W (`MEM_ADDR_W)
    ) u_ram (
        .clk (clk),
        .mem (u_mem_if.ram)
    );

endmodule

// ==== test/ecc_mem_assertions.sv ====
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_mem_assertions import ecc_pkg::*, mem_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic                  wr_en,
    input logic                  rd_en,
    input mem_addr_t             addr,
    input mem_data_t             wr_data,
    input code_word_t            inject_mask,
    input logic                  rd_valid,
    input mem_data_t             rd_data,
    input ecc_status_e           rd_status,
    input logic [`ECC_CNT_W-1:0] corr_count
);

    localparam int DEPTH = 1 << `MEM_ADDR_W;

    int unsigned fail_count = 0; // Polled by the testbench.

    mem_data_t             shadow_data [0:DEPTH-1]; // Last written data per address.
    code_word_t            shadow_mask [0:DEPTH-1]; // Inject mask it went in with.
    logic                  shadow_set  [0:DEPTH-1]; // Written since reset.
    mem_data_t             issue_data;              // Expected result of a read issued now.
    ecc_status_e           issue_status;
    logic [1:0]            p_valid;                 // Reads in flight.
    logic [1:0]            p_known;
    mem_data_t             p_data   [0:1];
    ecc_status_e           p_status [0:1];
    logic                  exp_valid;               // Lines up with rd_valid.
    logic                  exp_known;
    mem_data_t             exp_data;
    ecc_status_e           exp_status;
    logic [`ECC_CNT_W-1:0] exp_count;

    // XOR of the positions of all flipped bits.
    function automatic int unsigned mask_syndrome(input code_word_t mask);
        int unsigned syn;
        syn = 0;
        for (int unsigned pos = 1; pos <= `ECC_CODE_W; pos++) begin
            if (mask[pos-1]) begin
                syn = syn ^ pos;
            end
        end
        return syn;
    endfunction

    // Data field of a codeword, parity sits at 1, 2, 4, 8, 16 and 32.
    function automatic mem_data_t data_field(input code_word_t word);
        mem_data_t   d;
        int unsigned k;
        d = '0;
        k = 0;
        for (int unsigned pos = 1; pos <= `ECC_CODE_W; pos++) begin
            if (!(pos inside {1, 2, 4, 8, 16, 32})) begin
                d[k] = word[pos-1];
                k    = k + 1;
            end
        end
        return d;
    endfunction

    // Predict the decoder from the stored mask alone.
    always_comb begin
        int unsigned syn;
        code_word_t  left;
        syn  = mask_syndrome(shadow_mask[addr]);
        left = shadow_mask[addr]; // Flips still present after correction.
        if (syn == 0) begin
            issue_status = ECC_CLEAN;
        end else if (syn <= `ECC_CODE_W) begin
            issue_status = ECC_CORRECTED;
            left[syn-1]  = ~left[syn-1]; // Decoder flips this one back, right or wrong.
        end else begin
            issue_status = ECC_BAD_SYNDROME; // Passed through raw.
        end
        issue_data = shadow_data[addr] ^ data_field(left);
    end

    always @(posedge clk) begin
        if (reset) begin
            p_valid   <= '0;
            exp_valid <= 1'b0;
            exp_count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                shadow_set[i] <= 1'b0;
            end
        end else begin
            p_valid     <= {p_valid[0], (rd_en && !wr_en)}; // Write wins.
            p_known     <= {p_known[0], shadow_set[addr]};
            p_data[0]   <= issue_data;
            p_data[1]   <= p_data[0];
            p_status[0] <= issue_status;
            p_status[1] <= p_status[0];
            exp_valid   <= p_valid[1];
            exp_known   <= p_known[1];
            exp_data    <= p_data[1];
            exp_status  <= p_status[1];
            if (p_valid[1] && p_status[1] == ECC_CORRECTED && !(&exp_count)) begin
                exp_count <= exp_count + 1'b1; // Sticks at all ones.
            end
            if (wr_en) begin
                shadow_data[addr] <= wr_data;
                shadow_mask[addr] <= inject_mask;
                shadow_set[addr]  <= 1'b1;
            end
        end
    end

    a_valid_timing: assert property (@(posedge clk) disable iff (reset)
        rd_valid == exp_valid)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH valid_timing expected %0b actual %0b",
                   $sampled(exp_valid), $sampled(rd_valid));
        end

    a_read_data: assert property (@(posedge clk) disable iff (reset)
        (rd_valid && exp_known) |-> rd_data == exp_data)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH read_data expected %08h actual %08h",
                   $sampled(exp_data), $sampled(rd_data));
        end

    a_read_status: assert property (@(posedge clk) disable iff (reset)
        (rd_valid && exp_known) |-> rd_status == exp_status)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH read_status expected %0d actual %0d",
                   $sampled(exp_status), $sampled(rd_status));
        end

    a_corr_count: assert property (@(posedge clk) disable iff (reset)
        corr_count == exp_count)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH corr_count expected %0d actual %0d",
                   $sampled(exp_count), $sampled(corr_count));
        end

endmodule

bind ecc_mem_top ecc_mem_assertions u_assert (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .addr        (addr),
    .wr_data     (wr_data),
    .inject_mask (inject_mask),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rd_status   (rd_status),
    .corr_count  (corr_count)
);

// ==== test/tb_ecc_mem_top.sv ====
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module tb_ecc_mem_top import ecc_pkg::*, mem_pkg::*; ();

    logic                  clk;
    logic                  reset;
    logic                  wr_en;
    logic                  rd_en;
    mem_addr_t             addr;
    mem_data_t             wr_data;
    code_word_t            inject_mask;
    logic                  rd_valid;
    mem_data_t             rd_data;
    ecc_status_e           rd_status;
    logic [`ECC_CNT_W-1:0] corr_count;
    integer                seed; // Random stream state.

    ecc_mem_top u_ecc_mem_top (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (addr),
        .wr_data     (wr_data),
        .inject_mask (inject_mask),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_status   (rd_status),
        .corr_count  (corr_count)
    );

    always #5 clk = ~clk; // 10 ns period.

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    // Applies one cycle of strobes at the next rising edge.
    task automatic drive_cycle(input logic we, input logic re, input mem_addr_t a,
                               input mem_data_t d, input code_word_t m);
        @(posedge clk);
        wr_en       <= we;
        rd_en       <= re;
        addr        <= a;
        wr_data     <= d;
        inject_mask <= m;
    endtask

    task automatic go_idle();
        drive_cycle(1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic wait_read_valid();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rd_valid !== 1'b1) begin
            if (cycles == 20) begin
                stop_with_failure("Timed out waiting for rd_valid.");
            end
            @(negedge clk);
            cycles = cycles + 1;
        end
    endtask

    // Writes a word and reads it back on the very next cycle.
    task automatic write_then_read(input mem_addr_t a, input mem_data_t d, input code_word_t m);
        drive_cycle(1'b1, 1'b0, a, d, m);
        drive_cycle(1'b0, 1'b1, a, '0, '0);
        go_idle();
        wait_read_valid();
    endtask

    function automatic code_word_t two_bit_mask(input int unsigned b0, input int unsigned b1);
        code_word_t m;
        m     = '0;
        m[b0] = 1'b1;
        m[b1] = m[b1] ^ 1'b1; // Same bit twice cancels.
        return m;
    endfunction

    // Any assertion failure ends the run.
    always @(negedge clk) begin
        if (u_ecc_mem_top.u_assert.fail_count != 0) begin
            stop_with_failure("A checker assertion failed.");
        end
    end

    initial begin
        int unsigned kind;
        int unsigned sel;
        code_word_t  m;
        seed        = 13445;
        clk         = 1'b0;
        reset       = 1'b1;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        addr        = '0;
        wr_data     = '0;
        inject_mask = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (5) go_idle(); // Quiet outputs with no reads yet.

        write_then_read(8'h00, 32'hDEADBEEF, '0);
        write_then_read(8'h01, 32'h00000000, '0);
        write_then_read(8'h02, 32'hFFFFFFFF, '0);

        // Back-to-back reads.
        drive_cycle(1'b0, 1'b1, 8'h00, '0, '0);
        drive_cycle(1'b0, 1'b1, 8'h01, '0, '0);
        drive_cycle(1'b0, 1'b1, 8'h02, '0, '0);
        go_idle();
        wait_read_valid();
        repeat (3) go_idle();

        // Single flip at every position over addresses 0 to 37.
        for (int b = 0; b < `ECC_CODE_W; b++) begin
            write_then_read(mem_addr_t'(b), $random(seed), code_word_t'(1) << b);
        end

        write_then_read(8'h30, $random(seed), two_bit_mask(37, 0));  // Syndrome 39.
        write_then_read(8'h31, $random(seed), two_bit_mask(31, 15)); // Syndrome 48.
        write_then_read(8'h32, $random(seed), two_bit_mask(36, 25)); // Syndrome 63.
        write_then_read(8'h33, $random(seed), two_bit_mask(2, 4));   // Miscorrects position 6.
        write_then_read(8'h34, $random(seed), two_bit_mask(0, 1));
        for (int n = 0; n < 8; n++) begin
            write_then_read(8'h35, $random(seed), two_bit_mask($unsigned($random(seed)) % 38,
                                                               $unsigned($random(seed)) % 38));
        end

        // Both strobes together so the write wins and no read follows.
        drive_cycle(1'b1, 1'b1, 8'h40, 32'h5A5A0F0F, '0);
        repeat (4) go_idle();
        drive_cycle(1'b0, 1'b1, 8'h40, '0, '0);
        go_idle();
        wait_read_valid();

        // Random traffic in the window 0 to 15 which was written above.
        for (int n = 0; n < 200; n++) begin
            kind = $unsigned($random(seed)) % 4;
            sel  = $unsigned($random(seed)) % 8;
            m    = '0;
            if (kind == 1) begin
                m[$unsigned($random(seed)) % 38] = 1'b1;
            end else if (kind == 2) begin
                m = two_bit_mask($unsigned($random(seed)) % 38, $unsigned($random(seed)) % 38);
            end
            drive_cycle(sel < 3 || sel == 7, sel >= 3, mem_addr_t'($unsigned($random(seed)) % 16),
                        $random(seed), m);
        end
        repeat (6) go_idle(); // Drain reads in flight.
        @(negedge clk);

        if (u_ecc_mem_top.u_assert.fail_count != 0) begin
            stop_with_failure("The checker reported failures.");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== ecc_mem_top.f ====
+incdir+common
common/ecc_pkg.sv
common/mem_pkg.sv
common/mem_port_if.sv
ecc/ecc_enc32.sv
ecc/ecc_dec32.sv
logic/ecc_ram.sv
logic/ecc_mem_ctrl.sv
logic/ecc_mem_top.sv
test/ecc_mem_assertions.sv
test/tb_ecc_mem_top.sv
